//--- design/monitor_pkg.sv
`default_nettype none

package monitor_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [18:0] sram_addr_t;

    // first byte of every command frame.
    typedef enum logic [7:0] {
        OP_WRITE    = 8'h57,  // addr2 addr1 addr0 data.
        OP_READ     = 8'h52,  // addr2 addr1 addr0.
        OP_GPIO_SET = 8'h47,  // data.
        OP_GPIO_GET = 8'h49
    } cmd_op_t;

    localparam byte_t REPLY_OK  = 8'h4B;
    localparam byte_t REPLY_BAD = 8'h3F;

    typedef struct packed {
        logic       write;
        sram_addr_t addr;
        byte_t      wdata;
    } sram_req_t;

endpackage

`default_nettype wire

//--- design/reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reset_gen #(
    parameter int RESET_CYCLES = 16
) (
    input  wire  CLK,
    input  wire  reset,
    output logic rst_int
);

    localparam int CW = $clog2(RESET_CYCLES + 1);

    logic [CW-1:0] cnt;

    // reload while held, then count down.
    always_ff @(posedge CLK)
    begin
        if (reset)
            cnt <= CW'(RESET_CYCLES);
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    assign rst_int = reset | (cnt != '0);

endmodule

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import monitor_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire   CLK,
    input  wire   reset,
    input  wire   rx,
    output logic  rx_valid,
    output byte_t rx_byte
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);

    rx_state_t     state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic          rx_meta;
    logic          rx_s;
    byte_t         shreg;

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_meta  <= 1'b1;  // idle line is high.
            rx_s     <= 1'b1;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_meta  <= rx;
            rx_s     <= rx_meta;
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE:
                begin
                    cnt <= '0;
                    if (!rx_s)
                        state <= RX_START;
                end
                RX_START:
                    if (cnt == HALF)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch check.
                    end
                RX_DATA:
                    if (cnt == LAST)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                RX_STOP:
                    if (cnt == LAST)
                    begin
                        rx_valid <= rx_s;  // bad stop bit drops the frame.
                        state    <= RX_IDLE;
                    end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge CLK)
    begin
        if (state == RX_DATA && cnt == LAST)
            shreg <= {rx_s, shreg[7:1]};
    end

    assign rx_byte = shreg;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import monitor_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire   CLK,
    input  wire   reset,
    input  wire   tx_valid,
    input  byte_t tx_byte,
    output logic  tx_ready,
    output logic  tx
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

    tx_state_t     state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          bit_end;

    assign tx_ready = (state == TX_IDLE);
    assign bit_end  = (cnt == LAST);

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end
        else
        begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE:
                begin
                    cnt <= '0;
                    if (tx_valid)
                    begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                end
                TX_START:
                    if (bit_end)
                    begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx      <= shreg[0];
                    end
                TX_DATA:
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end
                        else
                            tx <= shreg[0];
                    end
                TX_STOP:
                    if (bit_end)
                        state <= TX_IDLE;
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // shreg[0] always holds the next data bit.
    always_ff @(posedge CLK)
    begin
        if (tx_valid && tx_ready)
            shreg <= tx_byte;
        else if (bit_end && (state == TX_START || (state == TX_DATA && bit_idx != 3'd7)))
            shreg <= {1'b0, shreg[7:1]};
    end

endmodule

`default_nettype wire

//--- design/cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_engine
    import monitor_pkg::*;
(
    input  wire       CLK,
    input  wire       reset,

    input  wire       rx_valid,
    input  byte_t     rx_byte,

    output logic      req_valid,
    output sram_req_t req,
    input  wire       req_ready,

    input  wire       rsp_valid,
    input  byte_t     rsp_data,

    output logic      tx_valid,
    output byte_t     tx_byte,
    input  wire       tx_ready,

    input  byte_t     gpio_in,
    output byte_t     gpio_out
);

    typedef enum logic [2:0] {C_OP, C_ADDR, C_DATA, C_REQ, C_WAIT, C_REPLY} cmd_state_t;

    cmd_state_t state;
    cmd_op_t    op;
    sram_addr_t addr_q;
    byte_t      data_q;
    byte_t      reply_q;
    logic [1:0] arg_cnt;
    logic       is_write;

    assign is_write  = (op == OP_WRITE);
    assign req_valid = (state == C_REQ);
    assign tx_valid  = (state == C_REPLY);
    assign tx_byte   = reply_q;
    assign req       = '{write: is_write, addr: addr_q, wdata: data_q};

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state    <= C_OP;
            arg_cnt  <= '0;
            gpio_out <= '0;
        end
        else
        begin
            case (state)
                C_OP:
                    if (rx_valid)
                    begin
                        arg_cnt <= '0;
                        case (rx_byte)
                            OP_WRITE,
                            OP_READ:     state <= C_ADDR;
                            OP_GPIO_SET: state <= C_DATA;
                            default:     state <= C_REPLY;  // get or unknown.
                        endcase
                    end
                C_ADDR:
                    if (rx_valid)
                    begin
                        arg_cnt <= arg_cnt + 1'b1;
                        if (arg_cnt == 2'd2)
                            state <= is_write ? C_DATA : C_REQ;
                    end
                C_DATA:
                    if (rx_valid)
                    begin
                        if (op == OP_GPIO_SET)
                        begin
                            gpio_out <= rx_byte;
                            state    <= C_REPLY;
                        end
                        else
                            state <= C_REQ;
                    end
                C_REQ:
                    if (req_ready)
                        state <= is_write ? C_REPLY : C_WAIT;
                C_WAIT:
                    if (rsp_valid)
                        state <= C_REPLY;
                C_REPLY:
                    if (tx_ready)
                        state <= C_OP;  // rx bytes before this are lost.
                default:
                    state <= C_OP;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        case (state)
            C_OP:
                if (rx_valid)
                begin
                    op <= cmd_op_t'(rx_byte);
                    if (rx_byte == OP_GPIO_GET)
                        reply_q <= gpio_in;
                    else
                        reply_q <= REPLY_BAD;  // overwritten for valid ops.
                end
            C_ADDR:
                if (rx_valid)
                    addr_q <= {addr_q[10:0], rx_byte};  // top 5 bits fall off.
            C_DATA:
                if (rx_valid)
                begin
                    data_q  <= rx_byte;
                    reply_q <= REPLY_OK;
                end
            C_WAIT:
                if (rsp_valid)
                    reply_q <= rsp_data;
            default:
                ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/sram_port.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port
    import monitor_pkg::*;
#(
    parameter int SRAM_CYCLES = 2
) (
    input  wire        CLK,
    input  wire        reset,

    input  wire        req_valid,
    input  sram_req_t  req,
    output logic       req_ready,

    output logic       rsp_valid,
    output byte_t      rsp_data,

    output sram_addr_t addr,
    output byte_t      dq_out,
    input  byte_t      dq_in,
    output logic       dq_oe,
    output logic       ce_n,
    output logic       oe_n,
    output logic       we_n
);

    localparam int CW = $clog2(SRAM_CYCLES + 1);
    localparam logic [CW-1:0] LAST = CW'(SRAM_CYCLES - 1);

    logic          active;
    logic          wr;
    logic [CW-1:0] cnt;
    logic          last_cycle;

    assign req_ready  = !active;
    assign last_cycle = active && (cnt == LAST);

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            active    <= 1'b0;
            wr        <= 1'b0;
            cnt       <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (!active)
            begin
                if (req_valid)
                begin
                    active <= 1'b1;
                    wr     <= req.write;
                    cnt    <= '0;
                end
            end
            else if (last_cycle)
            begin
                active    <= 1'b0;
                rsp_valid <= !wr;
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    // address and data held for the whole access.
    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            addr   <= req.addr;
            dq_out <= req.wdata;
        end
        if (last_cycle && !wr)
            rsp_data <= dq_in;
    end

    assign dq_oe = active & wr;
    assign we_n  = !dq_oe;
    assign oe_n  = !(active & !wr);
    assign ce_n  = !active;

endmodule

`default_nettype wire

//--- design/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top
    import monitor_pkg::*;
#(
    parameter int CLKS_PER_BIT = 104,
    parameter int RESET_CYCLES = 255,
    parameter int SRAM_CYCLES  = 2
) (
    input  wire        CLK,
    input  wire        reset,

    input  wire        rx,
    output logic       tx,

    input  byte_t      gpio_in,
    output byte_t      gpio_out,

    output sram_addr_t addr,
    output byte_t      dq_out,
    input  byte_t      dq_in,
    output logic       dq_oe,
    output logic       ce_n,
    output logic       oe_n,
    output logic       we_n
);

    logic      rst_int;
    logic      rx_valid;
    byte_t     rx_byte;
    logic      req_valid;
    sram_req_t req;
    logic      req_ready;
    logic      rsp_valid;
    byte_t     rsp_data;
    logic      tx_valid;
    byte_t     tx_byte;
    logic      tx_ready;

    reset_gen #(.RESET_CYCLES(RESET_CYCLES)) u_reset_gen (
        .CLK     (CLK),
        .reset   (reset),
        .rst_int (rst_int)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .CLK      (CLK),
        .reset    (rst_int),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    cmd_engine u_cmd_engine (
        .CLK       (CLK),
        .reset     (rst_int),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_ready  (tx_ready),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    // external pads split into dq_out, dq_in and dq_oe.
    sram_port #(.SRAM_CYCLES(SRAM_CYCLES)) u_sram_port (
        .CLK       (CLK),
        .reset     (rst_int),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .addr      (addr),
        .dq_out    (dq_out),
        .dq_in     (dq_in),
        .dq_oe     (dq_oe),
        .ce_n      (ce_n),
        .oe_n      (oe_n),
        .we_n      (we_n)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .CLK      (CLK),
        .reset    (rst_int),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

endmodule

`default_nettype wire

//--- test/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model
    import monitor_pkg::*;
(
    input  wire        CLK,
    input  sram_addr_t addr,
    input  byte_t      dq_out,
    output byte_t      dq_in,
    input  wire        dq_oe,
    input  wire        ce_n,
    input  wire        oe_n,
    input  wire        we_n
);

    byte_t mem [0:(1 << 19) - 1];

    // fill mixes every address bit into the byte.
    initial
    begin
        for (int i = 0; i < (1 << 19); i++)
            mem[sram_addr_t'(i)] = byte_t'(i ^ (i >> 8) ^ (i >> 16) ^ 8'h5C);
    end

    // write strobe sampled once per clock.
    always @(posedge CLK)
    begin
        if (!ce_n && !we_n && dq_oe)
            mem[addr] <= dq_out;
    end

    assign dq_in = (!ce_n && !oe_n) ? mem[addr] : '0;  // bus parked low.

endmodule

`default_nettype wire

//--- test/board_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module board_assertions
    import monitor_pkg::*;
(
    input wire        CLK,
    input wire        rst_int,
    input wire        tx,
    input wire        tx_ready,
    input sram_addr_t addr,
    input byte_t      dq_out,
    input wire        dq_oe,
    input wire        ce_n,
    input wire        oe_n,
    input wire        we_n
);

    // write strobe only with the bus driven, the chip selected and the pins held.
    a_write_pins: assert property (@(posedge CLK) disable iff (rst_int)
        !we_n |-> (dq_oe && !ce_n && ($past(we_n) || ($stable(addr) && $stable(dq_out)))))
        else $error("we_n low without dq_oe, ce_n low or stable addr and dq_out");

    a_no_bus_fight: assert property (@(posedge CLK) disable iff (rst_int)
        $rose(dq_oe) |-> ($past(oe_n) && oe_n))
        else $error("dq_oe rose while oe_n was low");

    // line idles high whenever the transmitter is free.
    a_tx_idle: assert property (@(posedge CLK) disable iff (rst_int) tx_ready |-> tx)
        else $error("tx is low while the transmitter is idle");

endmodule

bind board_top board_assertions u_board_assertions (
    .CLK      (CLK),
    .rst_int  (rst_int),
    .tx       (tx),
    .tx_ready (tx_ready),
    .addr     (addr),
    .dq_out   (dq_out),
    .dq_oe    (dq_oe),
    .ce_n     (ce_n),
    .oe_n     (oe_n),
    .we_n     (we_n)
);

`default_nettype wire

//--- test/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_top
    import monitor_pkg::*;
();

    localparam int CLKS_PER_BIT  = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int SRAM_CYCLES   = 2;
    localparam int REPLY_TIMEOUT = 40 * CLKS_PER_BIT;
    localparam int RANDOM_WRITES = 32;

    typedef struct packed {
        byte_t       op;
        logic [23:0] addr_bytes;  // as sent, msb first.
        byte_t       data;
        byte_t       gpio_drive;
        byte_t       reply;
    } cmd_row_t;

    logic       CLK;
    logic       reset;
    logic       rx;
    logic       tx;
    byte_t      gpio_in;
    byte_t      gpio_out;
    sram_addr_t addr;
    byte_t      dq_out;
    byte_t      dq_in;
    logic       dq_oe;
    logic       ce_n;
    logic       oe_n;
    logic       we_n;

    cmd_row_t    rows [$];
    logic [31:0] lfsr;
    byte_t       gpio_shadow;
    byte_t       mem_shadow [sram_addr_t];
    sram_addr_t  seen_addr;
    byte_t       seen_data;
    int          write_cycles;

    board_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .RESET_CYCLES (RESET_CYCLES),
        .SRAM_CYCLES  (SRAM_CYCLES)
    ) u_board_top (
        .CLK      (CLK),
        .reset    (reset),
        .rx       (rx),
        .tx       (tx),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .addr     (addr),
        .dq_out   (dq_out),
        .dq_in    (dq_in),
        .dq_oe    (dq_oe),
        .ce_n     (ce_n),
        .oe_n     (oe_n),
        .we_n     (we_n)
    );

    sram_model u_sram_model (
        .CLK    (CLK),
        .addr   (addr),
        .dq_out (dq_out),
        .dq_in  (dq_in),
        .dq_oe  (dq_oe),
        .ce_n   (ce_n),
        .oe_n   (oe_n),
        .we_n   (we_n)
    );

    initial
        CLK = 1'b0;

    always #4 CLK = ~CLK;

    // pins seen during each write cycle.
    always @(negedge CLK)
    begin
        if (!we_n)
        begin
            seen_addr = addr;
            seen_data = dq_out;
            write_cycles++;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%02h, expected 0x%02h",
                                $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%05h, expected 0x%05h",
                                $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic cmd_row_t make_row(input byte_t op, input logic [23:0] a,
                                          input byte_t d, input byte_t gin, input byte_t rep);
        cmd_row_t r;
        r.op         = op;
        r.addr_bytes = a;
        r.data       = d;
        r.gpio_drive = gin;
        r.reply      = rep;
        return r;
    endfunction

    // 8n1, lsb first.
    task automatic send_byte(input byte_t b);
        byte_t sh;
        sh = b;
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge CLK);
        for (int i = 0; i < 8; i++)
        begin
            rx = sh[0];
            sh = sh >> 1;
            repeat (CLKS_PER_BIT) @(negedge CLK);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge CLK);
    endtask

    task automatic send_frame(input byte_t op, input logic [23:0] a, input byte_t d);
        @(negedge CLK);
        send_byte(op);
        if (op == OP_WRITE || op == OP_READ)
        begin
            send_byte(a[23:16]);
            send_byte(a[15:8]);
            send_byte(a[7:0]);
        end
        if (op == OP_WRITE || op == OP_GPIO_SET)
            send_byte(d);
    endtask

    task automatic receive_reply(output byte_t value);
        int    waited;
        byte_t v;
        waited = 0;
        while (tx !== 1'b0)
        begin
            if (waited >= REPLY_TIMEOUT)
                abort_run("no reply start bit appeared on tx before the timeout");
            @(negedge CLK);
            waited++;
        end
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge CLK);  // to mid start bit.
        if (tx !== 1'b0)
            abort_run("reply start bit on tx ended too early");
        v = '0;
        for (int i = 0; i < 8; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge CLK);
            v = {tx, v[7:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge CLK);
        if (tx !== 1'b1)
            abort_run("reply stop bit on tx is low");
        value = v;
    endtask

    task automatic run_command(input cmd_row_t r);
        byte_t reply;
        int    cycles_before;
        gpio_in       = r.gpio_drive;
        cycles_before = write_cycles;
        send_frame(r.op, r.addr_bytes, r.data);
        receive_reply(reply);
        check_byte("reply", reply, r.reply);
        if (r.op == OP_WRITE)
        begin
            check_addr("addr", seen_addr, r.addr_bytes[18:0]);
            check_byte("dq_out", seen_data, r.data);
            if (write_cycles != cycles_before + SRAM_CYCLES)
                abort_run("write strobe did not last exactly SRAM_CYCLES cycles");
        end
        else if (write_cycles != cycles_before)
            abort_run("we_n went low during a command that is not a write");
        if (r.op == OP_GPIO_SET)
            gpio_shadow = r.data;
        check_byte("gpio_out", gpio_out, gpio_shadow);
    endtask

    task automatic load_table();
        rows.push_back(make_row(OP_WRITE,    24'h000000, 8'hA5, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_WRITE,    24'h07FFFF, 8'h3C, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_WRITE,    24'hF81234, 8'h5E, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_WRITE,    24'h02ABCD, 8'h77, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_READ,     24'h000000, 8'h00, 8'h00, 8'hA5));
        rows.push_back(make_row(OP_READ,     24'h07FFFF, 8'h00, 8'h00, 8'h3C));
        rows.push_back(make_row(OP_READ,     24'h001234, 8'h00, 8'h00, 8'h5E));
        rows.push_back(make_row(OP_READ,     24'h02ABCD, 8'h00, 8'h00, 8'h77));
        rows.push_back(make_row(OP_WRITE,    24'h02ABCD, 8'h88, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_READ,     24'h02ABCD, 8'h00, 8'h00, 8'h88));
        rows.push_back(make_row(OP_GPIO_SET, 24'h000000, 8'hC3, 8'h00, REPLY_OK));
        rows.push_back(make_row(OP_GPIO_GET, 24'h000000, 8'h00, 8'h96, 8'h96));
        rows.push_back(make_row(8'h5A,       24'h000000, 8'h00, 8'h00, REPLY_BAD));
        rows.push_back(make_row(OP_GPIO_GET, 24'h000000, 8'h00, 8'h5A, 8'h5A));
        rows.push_back(make_row(OP_READ,     24'h001234, 8'h00, 8'h00, 8'h5E));
        rows.push_back(make_row(OP_GPIO_SET, 24'h000000, 8'h00, 8'h00, REPLY_OK));
    endtask

    initial
    begin
        logic [31:0] bits;
        logic [23:0] raw_addrs [$];
        logic [23:0] raw;
        byte_t       data;
        reset        = 1'b1;
        rx           = 1'b1;
        gpio_in      = '0;
        lfsr         = 32'h0ce5_742b;
        gpio_shadow  = '0;
        write_cycles = 0;
        load_table();

        repeat (5) @(negedge CLK);
        reset = 1'b0;
        repeat (RESET_CYCLES + 2) @(negedge CLK);  // internal reset stretch.

        check_bit("tx", tx, 1'b1);
        check_byte("gpio_out", gpio_out, 8'h00);
        check_bit("we_n", we_n, 1'b1);
        check_bit("ce_n", ce_n, 1'b1);
        check_bit("oe_n", oe_n, 1'b1);
        check_bit("dq_oe", dq_oe, 1'b0);

        for (int i = 0; i < rows.size(); i++)
            run_command(rows[i]);

        for (int i = 0; i < RANDOM_WRITES; i++)
        begin
            bits = draw_bits(24);
            raw  = bits[23:0];
            bits = draw_bits(8);
            data = bits[7:0];
            mem_shadow[raw[18:0]] = data;
            raw_addrs.push_back(raw);
            run_command(make_row(OP_WRITE, raw, data, 8'h00, REPLY_OK));
        end
        for (int i = 0; i < raw_addrs.size(); i++)
        begin
            raw = raw_addrs[i];
            run_command(make_row(OP_READ, raw, 8'h00, 8'h00, mem_shadow[raw[18:0]]));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/monitor_pkg.sv
design/reset_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_engine.sv
design/sram_port.sv
design/board_top.sv
test/sram_model.sv
test/board_assertions.sv
test/tb_board_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_board_top -f tb.f -o sim_board

status=0
./obj_dir/sim_board > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
